// ==== build.f ====
hdl/ks10Pkg.sv
hdl/cpuIntf.sv
hdl/cpuTimer.sv
hdl/cpuApr.sv
hdl/cpuIntr.sv
hdl/cpuCtl.sv
dv/cpuCtl_props.sv
dv/cpuCtlTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cpuCtlTb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/cpuCtlTb.sv ====
`timescale 1ns/1ps

module cpuCtlTb;

   localparam int tickDiv = 5;

   logic                 clk;
   logic                 arstN;
   logic                 clken;
   ks10Pkg::ctlFuncT     ctlFunc;
   ks10Pkg::word36T      dp;
   logic                 cslRun, cslHalt, cslCont, cslExec;
   logic                 cslTimerEn, cslIntrI, nxmIntr;
   ks10Pkg::intLinesT    ubaIntr;
   logic                 cpuRun, cpuHalt, cpuCont, cpuExec, cpuIntr, cslIntrO;
   ks10Pkg::intLevelT    reqIntP, curIntP;
   ks10Pkg::aprFlagsT    aprFlags;
   ks10Pkg::timerCountT  timerCount;

   // Model state
   logic                 mdlRun, mdlHalt, mdlCont, mdlExec;
   int                   mdlPre;
   logic                 mdlTick;
   ks10Pkg::timerCountT  mdlCount;
   ks10Pkg::aprFlagsT    mdlFlags, mdlEnables;
   ks10Pkg::intLevelT    mdlLevel;
   logic                 mdlPiOn;
   ks10Pkg::intLinesT    mdlPiEn, mdlSwReq, mdlInProg;

   int                   errors;
   int                   timeouts;
   int                   cycles;
   logic                 checkOn = 1'b0;

   cpuCtl #(.tickDiv(tickDiv)) dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////
   // Reference model
   ////////////////////

   function automatic ks10Pkg::intLinesT lineOf(input ks10Pkg::intLevelT lvl);
      ks10Pkg::intLinesT lines;
      lines = '0;
      for (int n = 1; n <= 7; n++) begin
         if (lvl == 3'(n)) lines[n-1] = 1'b1;
      end
      return lines;
   endfunction

   // Level 1 is checked first
   function automatic ks10Pkg::intLevelT firstLevel(input ks10Pkg::intLinesT lines);
      ks10Pkg::intLevelT lvl;
      lvl = '0;
      for (int n = 1; n <= 7; n++) begin
         if (lines[n-1] && lvl == 3'd0) lvl = 3'(n);
      end
      return lvl;
   endfunction

   function automatic ks10Pkg::intLinesT expActive(input ks10Pkg::intLinesT uba);
      ks10Pkg::intLinesT apr;
      apr = ((mdlFlags & mdlEnables) != 8'd0) ? lineOf(mdlLevel) : 7'd0;
      if (!mdlPiOn) return '0;
      return (apr | uba | mdlSwReq) & mdlPiEn;
   endfunction

   function automatic logic expCpuIntr(input ks10Pkg::intLinesT uba);
      ks10Pkg::intLevelT req;
      ks10Pkg::intLevelT cur;
      req = firstLevel(expActive(uba));
      cur = firstLevel(mdlInProg);
      return (req != 3'd0) && (cur == 3'd0 || req < cur);
   endfunction

   function automatic void resetModel();
      {mdlRun, mdlHalt, mdlCont, mdlExec, mdlTick, mdlPiOn} = '0;
      mdlPre     = 0;
      mdlCount   = '0;
      mdlFlags   = '0;
      mdlEnables = '0;
      mdlLevel   = '0;
      mdlPiEn    = '0;
      mdlSwReq   = '0;
      mdlInProg  = '0;
   endfunction

   // One enabled edge, from the inputs seen just before it
   function automatic void refStep();
      logic              grant;
      logic              wrap;
      ks10Pkg::intLinesT reqLn;
      ks10Pkg::intLinesT curLn;
      ks10Pkg::aprFlagsT flags;
      grant = (ctlFunc == ks10Pkg::FN_PI_ACK) && expCpuIntr(ubaIntr);
      reqLn = lineOf(firstLevel(expActive(ubaIntr)));
      curLn = lineOf(firstLevel(mdlInProg));

      mdlRun = cslRun;
      if (cslHalt) begin
         mdlHalt = 1'b1;
      end else if (cslCont || cslExec) begin
         mdlHalt = 1'b0;
      end
      mdlCont = cslCont || (mdlCont && ctlFunc != ks10Pkg::FN_CSL_ACK);
      mdlExec = cslExec || (mdlExec && ctlFunc != ks10Pkg::FN_CSL_ACK);

      flags = mdlFlags;
      if (ctlFunc == ks10Pkg::FN_APR_CLR) flags = flags & ~dp[7:0];
      if (ctlFunc == ks10Pkg::FN_APR_SET) flags = flags | dp[7:0];
      flags[0] = flags[0] | nxmIntr;
      flags[1] = flags[1] | cslIntrI;
      flags[2] = flags[2] | mdlTick;       // Tick from the previous edge
      mdlFlags = flags;
      if (ctlFunc == ks10Pkg::FN_APR_ENABLE) begin
         mdlEnables = dp[7:0];
         mdlLevel   = dp[10:8];
      end

      wrap    = cslTimerEn && (mdlPre == tickDiv - 1);
      mdlTick = wrap;
      if (wrap) begin
         mdlPre   = 0;
         mdlCount = mdlCount + 18'd1;
      end else if (cslTimerEn) begin
         mdlPre = mdlPre + 1;
      end

      if (ctlFunc == ks10Pkg::FN_PI_LOAD) begin
         mdlPiOn  = dp[14];
         mdlPiEn  = dp[13:7];
         mdlSwReq = dp[6:0];
      end
      if (grant) begin
         mdlInProg = mdlInProg | reqLn;
         mdlSwReq  = mdlSwReq & ~reqLn;
      end
      if (ctlFunc == ks10Pkg::FN_PI_DISMISS) mdlInProg = mdlInProg & ~curLn;
   endfunction

   always @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         resetModel();
      end else if (clken) begin
         refStep();
      end
   end

   ////////////////////
   // Comparison
   ////////////////////

   task automatic reportMismatch(input string name, input logic [35:0] expVal,
                                 input logic [35:0] gotVal);
      $display("[FAIL] %s expected %h got %h at %0t", name, expVal, gotVal, $time);
      errors++;
   endtask

   task automatic compareOutputs();
      ks10Pkg::intLevelT expReq;
      ks10Pkg::intLevelT expCur;
      logic              expIntr;
      expReq  = firstLevel(expActive(ubaIntr));
      expCur  = firstLevel(mdlInProg);
      expIntr = expCpuIntr(ubaIntr);
      cycles++;
      if (cpuRun !== mdlRun) reportMismatch("cpuRun", 36'(mdlRun), 36'(cpuRun));
      if (cpuHalt !== mdlHalt) reportMismatch("cpuHalt", 36'(mdlHalt), 36'(cpuHalt));
      if (cpuCont !== mdlCont) reportMismatch("cpuCont", 36'(mdlCont), 36'(cpuCont));
      if (cpuExec !== mdlExec) reportMismatch("cpuExec", 36'(mdlExec), 36'(cpuExec));
      if (aprFlags !== mdlFlags) reportMismatch("aprFlags", 36'(mdlFlags), 36'(aprFlags));
      if (cslIntrO !== mdlFlags[7]) reportMismatch("cslIntrO", 36'(mdlFlags[7]), 36'(cslIntrO));
      if (timerCount !== mdlCount) begin
         reportMismatch("timerCount", 36'(mdlCount), 36'(timerCount));
      end
      if (reqIntP !== expReq) reportMismatch("reqIntP", 36'(expReq), 36'(reqIntP));
      if (curIntP !== expCur) reportMismatch("curIntP", 36'(expCur), 36'(curIntP));
      if (cpuIntr !== expIntr) reportMismatch("cpuIntr", 36'(expIntr), 36'(cpuIntr));
   endtask

   always @(negedge clk) begin
      if (checkOn) compareOutputs();
   end

   ////////////////////
   // Stimulus
   ////////////////////

   function automatic logic chance(input int unsigned pct);
      return $urandom_range(99, 0) < pct;
   endfunction

   task automatic driveFunc(input ks10Pkg::ctlFuncT fn, input ks10Pkg::word36T d,
                            input logic tEn);
      @(posedge clk);
      clken      <= 1'b1;
      ctlFunc    <= fn;
      dp         <= d;
      {cslHalt, cslCont, cslExec, cslIntrI, nxmIntr} <= '0;
      cslTimerEn <= tEn;
      ubaIntr    <= '0;
   endtask

   task automatic driveRandom(input int cycleCnt, input int unsigned enPct,
                              input int unsigned pulsePct);
      for (int i = 0; i < cycleCnt; i++) begin
         @(posedge clk);
         clken      <= chance(enPct);
         ctlFunc    <= ks10Pkg::ctlFuncT'($urandom_range(7, 0));
         dp         <= {4'($urandom()), $urandom()};
         cslRun     <= chance(50);
         cslHalt    <= chance(pulsePct);
         cslCont    <= chance(pulsePct);
         cslExec    <= chance(pulsePct);
         cslIntrI   <= chance(pulsePct / 2);
         nxmIntr    <= chance(pulsePct / 2);
         cslTimerEn <= chance(85);
         ubaIntr    <= 7'($urandom()) & 7'($urandom()) & 7'($urandom());
      end
   endtask

   task automatic waitForIntr(input int limit);
      logic seen;
      seen = 1'b0;
      for (int n = 0; n < limit && !seen; n++) begin
         driveFunc(ks10Pkg::FN_NOP, '0, 1'b0);
         @(negedge clk);
         seen = (cpuIntr === 1'b1);
      end
      if (!seen) begin
         $display("Timeout: cpuIntr did not rise within %0d cycles", limit);
         timeouts++;
      end
   endtask

   task automatic waitTimerTicks(input int ticks, input int limit);
      ks10Pkg::timerCountT target;
      logic                done;
      @(negedge clk);
      target = timerCount + 18'(ticks);
      done   = 1'b0;
      for (int n = 0; n < limit && !done; n++) begin
         driveFunc(ks10Pkg::FN_NOP, '0, 1'b1);
         @(negedge clk);
         done = (timerCount === target);
      end
      if (!done) begin
         $display("Timeout: timer did not advance %0d ticks in %0d cycles", ticks, limit);
         timeouts++;
      end
   endtask

   // Requests at 7, 4 and 2 nest, then unwind
   task automatic nestLevels();
      ks10Pkg::intLevelT lvls[3];
      lvls = '{3'd7, 3'd4, 3'd2};
      for (int i = 0; i < 3; i++) begin
         driveFunc(ks10Pkg::FN_PI_LOAD, (36'd1 << 14) | (36'h7f << 7) | 36'(lineOf(lvls[i])),
                   1'b0);
         waitForIntr(20);
         driveFunc(ks10Pkg::FN_PI_ACK, '0, 1'b0);
      end
      repeat (4) driveFunc(ks10Pkg::FN_PI_DISMISS, '0, 1'b0);
      driveFunc(ks10Pkg::FN_NOP, '0, 1'b0);
   endtask

   task automatic pulseReset();
      @(posedge clk);
      arstN <= 1'b0;
      repeat (3) @(posedge clk);
      arstN <= 1'b1;
   endtask

   initial begin
      void'($urandom(32'h4d5a_3771));
      errors     = 0;
      timeouts   = 0;
      cycles     = 0;
      arstN      = 1'b0;
      clken      = 1'b0;
      ctlFunc    = ks10Pkg::FN_NOP;
      dp         = '0;
      {cslRun, cslHalt, cslCont, cslExec} = '0;
      {cslTimerEn, cslIntrI, nxmIntr}     = '0;
      ubaIntr    = '0;

      @(posedge clk);
      checkOn = 1'b1;
      repeat (2) @(posedge clk);
      arstN <= 1'b1;

      nestLevels();
      waitTimerTicks(4, 4 * tickDiv + 10);
      driveRandom(500, 100, 15);
      driveRandom(400, 60, 20);
      driveRandom(40, 0, 50);              // Frozen datapath
      pulseReset();
      nestLevels();
      driveRandom(300, 80, 10);
      @(negedge clk);
      @(posedge clk);                      // Let the last comparison finish

      $display("Cycles checked %0d, mismatches %0d, timeouts %0d", cycles, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== dv/cpuCtl_props.sv ====
`timescale 1ns/1ps

module cpuCtlProps (
   input logic               clk,
   input logic               arstN,
   input logic               cpuRun,
   input logic               cpuHalt,
   input logic               cpuCont,
   input logic               cpuExec,
   input logic               cpuIntr,
   input logic               cslIntrO,
   input ks10Pkg::intLevelT  reqIntP,
   input ks10Pkg::intLevelT  curIntP,
   input ks10Pkg::intLinesT  aprIntr
);

   ////////////////////
   // Reset values
   ////////////////////

   resetQuiet: assert property (@(posedge clk)
      !arstN |=> (!cpuRun && !cpuHalt && !cpuCont && !cpuExec && !cpuIntr && !cslIntrO &&
                  reqIntP == 3'd0 && curIntP == 3'd0))
      else $error("Status outputs not clear after reset");

   // Level encoding
   intrHasLevel: assert property (@(posedge clk) disable iff (!arstN)
      cpuIntr |-> reqIntP != 3'd0)
      else $error("cpuIntr set with no requested level");

   aprOneLine: assert property (@(posedge clk) disable iff (!arstN)
      $onehot0(aprIntr))
      else $error("APR drives more than one interrupt line");

endmodule

bind cpuCtl cpuCtlProps props0 (
   .clk      (clk),
   .arstN    (arstN),
   .cpuRun   (cpuRun),
   .cpuHalt  (cpuHalt),
   .cpuCont  (cpuCont),
   .cpuExec  (cpuExec),
   .cpuIntr  (cpuIntr),
   .cslIntrO (cslIntrO),
   .reqIntP  (reqIntP),
   .curIntP  (curIntP),
   .aprIntr  (aprIntr)
);

// ==== hdl/cpuCtl.sv ====
`timescale 1ns/1ps

module cpuCtl #(
   parameter int tickDiv = 1000       // Clocks per millisecond tick
) (
   input  logic                 clk,
   input  logic                 arstN,
   input  logic                 clken,      // Datapath clock enable
   input  ks10Pkg::ctlFuncT     ctlFunc,
   input  ks10Pkg::word36T      dp,
   input  logic                 cslRun,
   input  logic                 cslHalt,
   input  logic                 cslCont,
   input  logic                 cslExec,
   input  logic                 cslTimerEn,
   input  logic                 cslIntrI,
   input  logic                 nxmIntr,
   input  ks10Pkg::intLinesT    ubaIntr,
   output logic                 cpuRun,
   output logic                 cpuHalt,
   output logic                 cpuCont,
   output logic                 cpuExec,
   output logic                 cpuIntr,
   output logic                 cslIntrO,
   output ks10Pkg::intLevelT    reqIntP,
   output ks10Pkg::intLevelT    curIntP,
   output ks10Pkg::aprFlagsT    aprFlags,
   output ks10Pkg::timerCountT  timerCount
);

   logic              timerTick;     // Timer to APR flag
   ks10Pkg::intLinesT aprIntr;       // APR to PI

   ////////////////////
   // Console interface
   ////////////////////

   cpuIntf uIntf (
      .clk      (clk),
      .arstN    (arstN),
      .clken    (clken),
      .ctlFunc  (ctlFunc),
      .cslRun   (cslRun),
      .cslHalt  (cslHalt),
      .cslCont  (cslCont),
      .cslExec  (cslExec),
      .cpuRun   (cpuRun),
      .cpuHalt  (cpuHalt),
      .cpuCont  (cpuCont),
      .cpuExec  (cpuExec)
   );

   // Interval timer
   cpuTimer #(
      .tickDiv  (tickDiv)
   ) uTimer (
      .clk        (clk),
      .arstN      (arstN),
      .clken      (clken),
      .timerEn    (cslTimerEn),
      .timerTick  (timerTick),
      .timerCount (timerCount)
   );

   ////////////////////
   // APR and PI
   ////////////////////

   cpuApr uApr (
      .clk       (clk),
      .arstN     (arstN),
      .clken     (clken),
      .ctlFunc   (ctlFunc),
      .dp        (dp),
      .timerTick (timerTick),
      .nxmIntr   (nxmIntr),
      .cslIntrI  (cslIntrI),
      .aprFlags  (aprFlags),
      .aprIntr   (aprIntr),
      .cslIntrO  (cslIntrO)
   );

   cpuIntr uIntr (
      .clk      (clk),
      .arstN    (arstN),
      .clken    (clken),
      .ctlFunc  (ctlFunc),
      .dp       (dp),
      .aprIntr  (aprIntr),
      .ubaIntr  (ubaIntr),
      .reqIntP  (reqIntP),
      .curIntP  (curIntP),
      .cpuIntr  (cpuIntr)
   );

endmodule

// ==== hdl/cpuIntr.sv ====
`timescale 1ns/1ps

module cpuIntr (
   input  logic               clk,
   input  logic               arstN,
   input  logic               clken,
   input  ks10Pkg::ctlFuncT   ctlFunc,
   input  ks10Pkg::word36T    dp,
   input  ks10Pkg::intLinesT  aprIntr,
   input  ks10Pkg::intLinesT  ubaIntr,     // Unibus requests
   output ks10Pkg::intLevelT  reqIntP,
   output ks10Pkg::intLevelT  curIntP,
   output logic               cpuIntr
);

   logic              piOn;                // PI system on
   ks10Pkg::intLinesT piEnables;           // Per-level enables
   ks10Pkg::intLinesT swReq;               // Software requests
   ks10Pkg::intLinesT inProg;              // Levels in progress
   ks10Pkg::intLinesT actReq;
   ks10Pkg::intLinesT reqLine;
   ks10Pkg::intLinesT curLine;
   logic              piAck;
   logic              piDismiss;

   ////////////////////
   // Priority encoding
   ////////////////////

   assign actReq = (aprIntr | ubaIntr | swReq) & piEnables & {7{piOn}};

   assign reqIntP = ks10Pkg::lowestLevel(actReq);
   assign curIntP = ks10Pkg::lowestLevel(inProg);

   // Only a strictly higher priority breaks in
   assign cpuIntr = (reqIntP != 3'd0) &&
                    ((curIntP == 3'd0) || (reqIntP < curIntP));

   assign reqLine = ks10Pkg::levelLines(reqIntP);
   assign curLine = ks10Pkg::levelLines(curIntP);

   assign piAck     = (ctlFunc == ks10Pkg::FN_PI_ACK) && cpuIntr;
   assign piDismiss = (ctlFunc == ks10Pkg::FN_PI_DISMISS);

   ////////////////////
   // PI state
   ////////////////////

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         piOn      <= 1'b0;
         piEnables <= '0;
         swReq     <= '0;
         inProg    <= '0;
      end else if (clken) begin
         if (ctlFunc == ks10Pkg::FN_PI_LOAD) begin
            piOn      <= dp[ks10Pkg::piOnBit];
            piEnables <= dp[13:7];
            swReq     <= dp[6:0];
         end

         // Grant moves the request into progress
         if (piAck) begin
            inProg <= inProg | reqLine;
            swReq  <= swReq & ~reqLine;
         end

         if (piDismiss) begin
            inProg <= inProg & ~curLine;   // Nothing when no level is active
         end
      end
   end

endmodule

// ==== hdl/cpuApr.sv ====
`timescale 1ns/1ps

module cpuApr (
   input  logic               clk,
   input  logic               arstN,
   input  logic               clken,
   input  ks10Pkg::ctlFuncT   ctlFunc,
   input  ks10Pkg::word36T    dp,
   input  logic               timerTick,
   input  logic               nxmIntr,     // Memory timeout
   input  logic               cslIntrI,    // From console
   output ks10Pkg::aprFlagsT  aprFlags,
   output ks10Pkg::intLinesT  aprIntr,
   output logic               cslIntrO
);

   ks10Pkg::aprFlagsT aprEnables;          // Interrupt enable mask
   ks10Pkg::intLevelT aprLevel;            // Assigned PI level
   ks10Pkg::aprFlagsT flagsNext;
   ks10Pkg::aprFlagsT hwSet;
   logic              aprReq;

   // Hardware sources
   always_comb begin
      hwSet                    = '0;
      hwSet[ks10Pkg::aprNxm]   = nxmIntr;
      hwSet[ks10Pkg::aprCslIn] = cslIntrI;
      hwSet[ks10Pkg::aprTimer] = timerTick;
   end

   ////////////////////
   // Flag update
   ////////////////////

   // Clear first, then sets, so a set always wins
   always_comb begin
      flagsNext = aprFlags;
      if (ctlFunc == ks10Pkg::FN_APR_CLR) begin
         flagsNext = flagsNext & ~dp[7:0];
      end
      if (ctlFunc == ks10Pkg::FN_APR_SET) begin
         flagsNext = flagsNext | dp[7:0];
      end
      flagsNext = flagsNext | hwSet;
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         aprFlags   <= '0;
         aprEnables <= '0;
         aprLevel   <= '0;
      end else if (clken) begin
         aprFlags <= flagsNext;
         if (ctlFunc == ks10Pkg::FN_APR_ENABLE) begin
            aprEnables <= dp[7:0];
            aprLevel   <= dp[10:8];
         end
      end
   end

   ////////////////////
   // Interrupt outputs
   ////////////////////

   assign aprReq = |(aprFlags & aprEnables);

   // Level 0 gives no line
   assign aprIntr = aprReq ? ks10Pkg::levelLines(aprLevel) : '0;

   assign cslIntrO = aprFlags[ks10Pkg::aprIntCsl];

endmodule

// ==== hdl/cpuTimer.sv ====
`timescale 1ns/1ps

module cpuTimer #(
   parameter int tickDiv = 1000       // Enabled clocks per tick
) (
   input  logic                 clk,
   input  logic                 arstN,
   input  logic                 clken,
   input  logic                 timerEn,
   output logic                 timerTick,
   output ks10Pkg::timerCountT  timerCount
);

   localparam int preW = (tickDiv > 1) ? $clog2(tickDiv) : 1;
   localparam logic [preW-1:0] preLast = preW'(tickDiv - 1);

   logic [preW-1:0] preCount;         // Prescaler
   logic            preWrap;

   // Last prescaler state while running
   assign preWrap = timerEn && (preCount == preLast);

   ////////////////////
   // Prescaler and count
   ////////////////////

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         preCount   <= '0;
         timerTick  <= 1'b0;
         timerCount <= '0;
      end else if (clken) begin
         timerTick <= preWrap;      // One enabled cycle wide

         if (preWrap) begin
            preCount   <= '0;
            timerCount <= timerCount + 18'd1;   // Wraps at 18 bits
         end else if (timerEn) begin
            preCount <= preCount + preW'(1);
         end
         // Disabled timer holds the prescaler phase
      end
   end

endmodule

// ==== hdl/cpuIntf.sv ====
`timescale 1ns/1ps

module cpuIntf (
   input  logic              clk,
   input  logic              arstN,
   input  logic              clken,     // Datapath clock enable
   input  ks10Pkg::ctlFuncT  ctlFunc,
   input  logic              cslRun,
   input  logic              cslHalt,
   input  logic              cslCont,
   input  logic              cslExec,
   output logic              cpuRun,
   output logic              cpuHalt,
   output logic              cpuCont,
   output logic              cpuExec
);

   logic cslAck;

   assign cslAck = (ctlFunc == ks10Pkg::FN_CSL_ACK);

   ////////////////////
   // Run state registers
   ////////////////////

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         cpuRun  <= 1'b0;
         cpuHalt <= 1'b0;
         cpuCont <= 1'b0;
         cpuExec <= 1'b0;
      end else if (clken) begin
         cpuRun <= cslRun;          // Plain level from console

         // Halt beats a simultaneous continue or execute
         if (cslHalt) begin
            cpuHalt <= 1'b1;
         end else if (cslCont || cslExec) begin
            cpuHalt <= 1'b0;
         end

         // Latched until microcode acknowledges
         if (cslCont) begin
            cpuCont <= 1'b1;
         end else if (cslAck) begin
            cpuCont <= 1'b0;
         end

         if (cslExec) begin
            cpuExec <= 1'b1;
         end else if (cslAck) begin
            cpuExec <= 1'b0;
         end
      end
   end

endmodule

// ==== hdl/ks10Pkg.sv ====
package ks10Pkg;

   ////////////////////
   // Word and field types
   ////////////////////

   typedef logic [35:0] word36T;      // Datapath word
   typedef logic [2:0]  intLevelT;    // 1 highest, 7 lowest, 0 none
   typedef logic [6:0]  intLinesT;    // Bit n-1 is level n
   typedef logic [7:0]  aprFlagsT;
   typedef logic [17:0] timerCountT;  // Millisecond count

   // APR flag positions
   localparam int aprNxm    = 0;      // Non-existent memory
   localparam int aprCslIn  = 1;      // Console interrupt in
   localparam int aprTimer  = 2;
   localparam int aprIntCsl = 7;      // Interrupt to console

   localparam int piOnBit = 14;       // PI system on, in a PI load word

   // Microcode functions
   typedef enum logic [2:0] {
      FN_NOP        = 3'd0,
      FN_APR_ENABLE = 3'd1,
      FN_APR_SET    = 3'd2,
      FN_APR_CLR    = 3'd3,
      FN_PI_LOAD    = 3'd4,
      FN_PI_ACK     = 3'd5,
      FN_PI_DISMISS = 3'd6,
      FN_CSL_ACK    = 3'd7
   } ctlFuncT;

   // One-hot line for a level, nothing for level 0
   function automatic intLinesT levelLines(input intLevelT lvl);
      intLinesT lines;
      lines = '0;
      if (lvl != 3'd0) lines = intLinesT'(7'b1 << (lvl - 3'd1));
      return lines;
   endfunction

   // Lowest-numbered set line wins
   function automatic intLevelT lowestLevel(input intLinesT lines);
      intLevelT lvl;
      lvl = '0;
      for (int n = 7; n >= 1; n--) begin
         if (lines[n-1]) lvl = intLevelT'(n);
      end
      return lvl;
   endfunction

endpackage
